/* hdl/rs5_lite_params.svh */
// rs5_lite core parameters
// Widths, reset address and the RV32I opcodes that decode matches

`ifndef RS5_LITE_PARAMS_SVH
`define RS5_LITE_PARAMS_SVH

// Datapath and register file
`define RS5_XLEN        32
`define RS5_REG_ADDR_W  5
`define RS5_NUM_REGS    32

// Fetch
`define RS5_RESET_PC    32'h0000_0000
`define RS5_PC_STEP     32'd4

// Major opcodes, instruction bits 6:0
`define RS5_OPC_LUI     7'b0110111
`define RS5_OPC_OP_IMM  7'b0010011
`define RS5_OPC_OP      7'b0110011
`define RS5_OPC_LOAD    7'b0000011
`define RS5_OPC_STORE   7'b0100011
`define RS5_OPC_BRANCH  7'b1100011
`define RS5_OPC_JAL     7'b1101111

`endif

/* hdl/rs5_lite_pkg.sv */
// rs5_lite shared types
// Operation and state encodings plus the bundles passed between stages

`include "rs5_lite_params.svh"

package rs5_lite_pkg;

    // Decoded operation, OP_NOP marks a bubble or unknown encoding
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_JAL
    } iop_e;

    // Pipeline control FSM
    typedef enum logic [1:0] {
        CTRL_BOOT,
        CTRL_RUN,
        CTRL_FLUSH,
        CTRL_LOAD_WAIT
    } ctrl_state_e;

    // Decode to execute
    typedef struct packed {
        logic                       valid;
        iop_e                       op;
        logic [`RS5_REG_ADDR_W-1:0] rd;
        logic [`RS5_XLEN-1:0]       first_op;
        // Immediate or rs2 value
        logic [`RS5_XLEN-1:0]       second_op;
        // Store data, or jump target for branches and JAL
        logic [`RS5_XLEN-1:0]       third_op;
        logic [`RS5_XLEN-1:0]       pc;
    } exec_req_t;

    // Register write-back
    typedef struct packed {
        logic                       we;
        logic [`RS5_REG_ADDR_W-1:0] rd;
        logic [`RS5_XLEN-1:0]       data;
    } wb_t;

    // Data memory request, unmasked by stall
    typedef struct packed {
        logic                       read;
        logic                       write;
        logic [`RS5_XLEN-1:0]       address;
        logic [`RS5_XLEN-1:0]       wdata;
    } mem_req_t;

endpackage

/* hdl/pipe_ctrl.sv */
// Pipeline control FSM
// Drops the boot word, flushes two words after a jump
// and holds fetch and decode while a load is outstanding

module pipe_ctrl (
    input  logic clk,
    input  logic rst_n_i,
    input  logic stall_i,
    input  logic jump_i,
    input  logic load_i,
    output logic enable_fetch_o,
    output logic enable_decode_o,
    output logic kill_decode_o,
    output logic hold_o
);

    rs5_lite_pkg::ctrl_state_e state, next_state;
    logic                      advance;

    ////////////////////////////////
    // State register
    ////////////////////////////////

    // Frozen while stalled, so a flush or load wait survives a stall
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= rs5_lite_pkg::CTRL_BOOT;
        end else if (!stall_i) begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            rs5_lite_pkg::CTRL_BOOT:      next_state = rs5_lite_pkg::CTRL_RUN;
            rs5_lite_pkg::CTRL_RUN: begin
                if (jump_i) begin
                    next_state = rs5_lite_pkg::CTRL_FLUSH;
                end else if (load_i) begin
                    next_state = rs5_lite_pkg::CTRL_LOAD_WAIT;
                end
            end
            rs5_lite_pkg::CTRL_FLUSH:     next_state = rs5_lite_pkg::CTRL_RUN;
            rs5_lite_pkg::CTRL_LOAD_WAIT: next_state = rs5_lite_pkg::CTRL_RUN;
            default:                      next_state = rs5_lite_pkg::CTRL_BOOT;
        endcase
    end

    ////////////////////////////////
    // Stage controls
    ////////////////////////////////

    // Load issue cycle keeps the LW in execute for a second cycle
    assign advance = !stall_i && !load_i;

    assign enable_fetch_o  = advance;
    assign enable_decode_o = advance;

    // Word in decode during the jump cycle is also stale
    assign kill_decode_o = (state == rs5_lite_pkg::CTRL_BOOT)
                        || (state == rs5_lite_pkg::CTRL_FLUSH)
                        || jump_i;

    // Load data returns in this cycle
    assign hold_o = (state == rs5_lite_pkg::CTRL_LOAD_WAIT);

endmodule

/* hdl/pc_counter.sv */
// Program counter
// Steps by one word or loads a jump target; pc_o tracks the arriving word

`include "rs5_lite_params.svh"

module pc_counter (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 enable_i,
    input  logic                 jump_i,
    input  logic [`RS5_XLEN-1:0] jump_target_i,
    output logic [`RS5_XLEN-1:0] instruction_address_o,
    output logic [`RS5_XLEN-1:0] pc_o
);

    // Next address to fetch
    logic [`RS5_XLEN-1:0] pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= `RS5_RESET_PC;
            pc_o <= `RS5_RESET_PC;
        end else if (jump_i) begin
            pc_q <= jump_target_i;
            pc_o <= instruction_address_o;
        end else if (enable_i) begin
            pc_q <= pc_q + `RS5_PC_STEP;
            pc_o <= pc_q;
        end
    end

    // Fetch memory is synchronous
    // When decode holds, refetch the word it still needs
    assign instruction_address_o = enable_i ? pc_q : pc_o;

endmodule

/* hdl/decode.sv */
// Decode stage
// Maps the RV32I subset to an operation, builds immediates and operands
// and registers the request for execute

`include "rs5_lite_params.svh"

module decode (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       enable_i,
    input  logic                       kill_i,
    input  logic [`RS5_XLEN-1:0]       instruction_i,
    input  logic [`RS5_XLEN-1:0]       pc_i,
    input  logic [`RS5_XLEN-1:0]       rs1_data_i,
    input  logic [`RS5_XLEN-1:0]       rs2_data_i,
    output logic [`RS5_REG_ADDR_W-1:0] rs1_o,
    output logic [`RS5_REG_ADDR_W-1:0] rs2_o,
    output rs5_lite_pkg::exec_req_t    req_o
);

    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [`RS5_XLEN-1:0]      imm_i, imm_s, imm_b, imm_u, imm_j;
    rs5_lite_pkg::iop_e        op;
    rs5_lite_pkg::exec_req_t   req_d;

    assign opcode = instruction_i[6:0];
    assign funct3 = instruction_i[14:12];
    assign funct7 = instruction_i[31:25];

    assign rs1_o = instruction_i[19:15];
    assign rs2_o = instruction_i[24:20];

    ////////////////////////////////
    // Immediates
    ////////////////////////////////

    assign imm_i = {{20{instruction_i[31]}}, instruction_i[31:20]};
    assign imm_s = {{20{instruction_i[31]}}, instruction_i[31:25], instruction_i[11:7]};
    assign imm_b = {{19{instruction_i[31]}}, instruction_i[31], instruction_i[7],
                    instruction_i[30:25], instruction_i[11:8], 1'b0};
    assign imm_u = {instruction_i[31:12], 12'b0};
    assign imm_j = {{11{instruction_i[31]}}, instruction_i[31], instruction_i[19:12],
                    instruction_i[20], instruction_i[30:21], 1'b0};

    ////////////////////////////////
    // Operation match
    ////////////////////////////////

    always_comb begin
        op = rs5_lite_pkg::OP_NOP;
        case (opcode)
            `RS5_OPC_LUI:    op = rs5_lite_pkg::OP_LUI;
            `RS5_OPC_JAL:    op = rs5_lite_pkg::OP_JAL;
            // Only ADDI among the immediate ALU ops
            `RS5_OPC_OP_IMM: if (funct3 == 3'b000) op = rs5_lite_pkg::OP_ADD;
            `RS5_OPC_LOAD:   if (funct3 == 3'b010) op = rs5_lite_pkg::OP_LW;
            `RS5_OPC_STORE:  if (funct3 == 3'b010) op = rs5_lite_pkg::OP_SW;
            `RS5_OPC_BRANCH: begin
                if (funct3 == 3'b000) op = rs5_lite_pkg::OP_BEQ;
                if (funct3 == 3'b001) op = rs5_lite_pkg::OP_BNE;
            end
            `RS5_OPC_OP: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = rs5_lite_pkg::OP_ADD;
                    10'b0100000_000: op = rs5_lite_pkg::OP_SUB;
                    10'b0000000_010: op = rs5_lite_pkg::OP_SLT;
                    10'b0000000_100: op = rs5_lite_pkg::OP_XOR;
                    10'b0000000_110: op = rs5_lite_pkg::OP_OR;
                    10'b0000000_111: op = rs5_lite_pkg::OP_AND;
                    default:         op = rs5_lite_pkg::OP_NOP;
                endcase
            end
            default:         op = rs5_lite_pkg::OP_NOP;
        endcase
    end

    ////////////////////////////////
    // Operand select
    ////////////////////////////////

    always_comb begin
        req_d.valid     = (op != rs5_lite_pkg::OP_NOP) && !kill_i;
        req_d.op        = op;
        req_d.rd        = instruction_i[11:7];
        req_d.first_op  = rs1_data_i;
        req_d.second_op = rs2_data_i;
        req_d.third_op  = '0;
        req_d.pc        = pc_i;
        case (op)
            rs5_lite_pkg::OP_ADD: begin
                if (opcode == `RS5_OPC_OP_IMM) req_d.second_op = imm_i;
            end
            rs5_lite_pkg::OP_LUI: req_d.second_op = imm_u;
            rs5_lite_pkg::OP_LW:  req_d.second_op = imm_i;
            rs5_lite_pkg::OP_SW: begin
                req_d.second_op = imm_s;
                req_d.third_op  = rs2_data_i;
                req_d.rd        = '0;
            end
            // Target computed here, execute only resolves the condition
            rs5_lite_pkg::OP_BEQ, rs5_lite_pkg::OP_BNE: begin
                req_d.third_op = pc_i + imm_b;
                req_d.rd       = '0;
            end
            rs5_lite_pkg::OP_JAL: req_d.third_op = pc_i + imm_j;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            req_o <= '0;
        end else if (enable_i) begin
            req_o <= req_d;
        end
    end

endmodule

/* hdl/regbank.sv */
// Register bank
// 31 flip-flop registers, two combinational reads, one write port

`include "rs5_lite_params.svh"

module regbank (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  rs5_lite_pkg::wb_t          wb_i,
    input  logic [`RS5_REG_ADDR_W-1:0] rs1_i,
    input  logic [`RS5_REG_ADDR_W-1:0] rs2_i,
    output logic [`RS5_XLEN-1:0]       data1_o,
    output logic [`RS5_XLEN-1:0]       data2_o
);

    // x0 has no storage
    logic [`RS5_XLEN-1:0] regs [1:`RS5_NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < `RS5_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && (wb_i.rd != '0)) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // Read side, x0 reads as zero
    assign data1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign data2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* hdl/execute.sv */
// Execute stage
// ALU, branch resolution, data memory request and write-back select
// LW takes two cycles here; data is written back in the hold cycle

`include "rs5_lite_params.svh"

module execute (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    hold_i,
    input  logic                    stall_i,
    input  rs5_lite_pkg::exec_req_t req_i,
    input  logic [`RS5_XLEN-1:0]    mem_data_i,
    output rs5_lite_pkg::wb_t       wb_o,
    output rs5_lite_pkg::mem_req_t  mem_o,
    output logic                    jump_o,
    output logic [`RS5_XLEN-1:0]    jump_target_o,
    output logic                    load_o
);

    logic [`RS5_XLEN-1:0] sum;
    logic [`RS5_XLEN-1:0] result;
    logic                 less;
    logic                 equal;
    logic                 taken;
    logic                 alu_we;
    logic                 load_pending;

    ////////////////////////////////
    // ALU
    ////////////////////////////////

    // Shared by ADD, ADDI and the memory address
    assign sum   = req_i.first_op + req_i.second_op;
    assign less  = $signed(req_i.first_op) < $signed(req_i.second_op);
    assign equal = (req_i.first_op == req_i.second_op);

    always_comb begin
        case (req_i.op)
            rs5_lite_pkg::OP_SUB: result = req_i.first_op - req_i.second_op;
            rs5_lite_pkg::OP_AND: result = req_i.first_op & req_i.second_op;
            rs5_lite_pkg::OP_OR:  result = req_i.first_op | req_i.second_op;
            rs5_lite_pkg::OP_XOR: result = req_i.first_op ^ req_i.second_op;
            rs5_lite_pkg::OP_SLT: result = {{(`RS5_XLEN-1){1'b0}}, less};
            rs5_lite_pkg::OP_LUI: result = req_i.second_op;
            // Link address
            rs5_lite_pkg::OP_JAL: result = req_i.pc + `RS5_PC_STEP;
            default:              result = sum;
        endcase
    end

    assign alu_we = req_i.valid && (req_i.op inside {
        rs5_lite_pkg::OP_ADD, rs5_lite_pkg::OP_SUB, rs5_lite_pkg::OP_AND,
        rs5_lite_pkg::OP_OR,  rs5_lite_pkg::OP_XOR, rs5_lite_pkg::OP_SLT,
        rs5_lite_pkg::OP_LUI, rs5_lite_pkg::OP_JAL});

    ////////////////////////////////
    // Branches and jumps
    ////////////////////////////////

    assign taken = req_i.valid
                && ((req_i.op == rs5_lite_pkg::OP_BEQ && equal)
                 || (req_i.op == rs5_lite_pkg::OP_BNE && !equal)
                 || (req_i.op == rs5_lite_pkg::OP_JAL));

    assign jump_o        = taken && !stall_i;
    assign jump_target_o = req_i.third_op;

    ////////////////////////////////
    // Memory and write-back
    ////////////////////////////////

    // Read only on the first LW cycle
    assign mem_o.read    = req_i.valid && (req_i.op == rs5_lite_pkg::OP_LW) && !load_pending;
    assign mem_o.write   = req_i.valid && (req_i.op == rs5_lite_pkg::OP_SW);
    assign mem_o.address = sum;
    assign mem_o.wdata   = req_i.third_op;

    assign load_o = mem_o.read && !stall_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            load_pending <= 1'b0;
        end else if (load_o) begin
            load_pending <= 1'b1;
        end else if (hold_i && !stall_i) begin
            load_pending <= 1'b0;
        end
    end

    assign wb_o.we   = !stall_i && (alu_we || (hold_i && load_pending));
    assign wb_o.rd   = req_i.rd;
    assign wb_o.data = load_pending ? mem_data_i : result;

endmodule

/* hdl/rs5_lite.sv */
// rs5_lite top level
// Three-stage RV32I subset core: fetch, decode, execute
// Holds the write-back forwarding mux and the data memory enables

`include "rs5_lite_params.svh"

module rs5_lite (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 stall_i,
    input  logic [`RS5_XLEN-1:0] instruction_i,
    input  logic [`RS5_XLEN-1:0] mem_data_i,
    output logic [`RS5_XLEN-1:0] instruction_address_o,
    output logic                 mem_operation_enable_o,
    output logic [3:0]           mem_write_enable_o,
    output logic [`RS5_XLEN-1:0] mem_address_o,
    output logic [`RS5_XLEN-1:0] mem_data_o
);

    ////////////////////////////////
    // Control
    ////////////////////////////////

    logic enable_fetch, enable_decode, kill_decode, hold;
    logic jump, load;

    ////////////////////////////////
    // Datapath
    ////////////////////////////////

    logic [`RS5_XLEN-1:0]       jump_target;
    logic [`RS5_XLEN-1:0]       pc_fetch;
    logic [`RS5_REG_ADDR_W-1:0] rs1, rs2;
    logic [`RS5_XLEN-1:0]       bank_data1, bank_data2;
    logic [`RS5_XLEN-1:0]       rs1_data, rs2_data;
    rs5_lite_pkg::exec_req_t    exec_req;
    rs5_lite_pkg::wb_t          wb;
    rs5_lite_pkg::mem_req_t     mem_req;

    pipe_ctrl u_pipe_ctrl (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .stall_i         (stall_i),
        .jump_i          (jump),
        .load_i          (load),
        .enable_fetch_o  (enable_fetch),
        .enable_decode_o (enable_decode),
        .kill_decode_o   (kill_decode),
        .hold_o          (hold)
    );

    pc_counter u_pc_counter (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .enable_i              (enable_fetch),
        .jump_i                (jump),
        .jump_target_i         (jump_target),
        .instruction_address_o (instruction_address_o),
        .pc_o                  (pc_fetch)
    );

    decode u_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .enable_i      (enable_decode),
        .kill_i        (kill_decode),
        .instruction_i (instruction_i),
        .pc_i          (pc_fetch),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .req_o         (exec_req)
    );

    regbank u_regbank (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wb_i    (wb),
        .rs1_i   (rs1),
        .rs2_i   (rs2),
        .data1_o (bank_data1),
        .data2_o (bank_data2)
    );

    // Write-back lands on the same edge decode samples, so bypass the bank
    assign rs1_data = (wb.we && (wb.rd != '0) && (wb.rd == rs1)) ? wb.data : bank_data1;
    assign rs2_data = (wb.we && (wb.rd != '0) && (wb.rd == rs2)) ? wb.data : bank_data2;

    execute u_execute (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .hold_i        (hold),
        .stall_i       (stall_i),
        .req_i         (exec_req),
        .mem_data_i    (mem_data_i),
        .wb_o          (wb),
        .mem_o         (mem_req),
        .jump_o        (jump),
        .jump_target_o (jump_target),
        .load_o        (load)
    );

    ////////////////////////////////
    // Data memory port
    ////////////////////////////////

    // Request waits in execute while stalled and fires once it drops
    assign mem_operation_enable_o = (mem_req.read || mem_req.write) && !stall_i;
    assign mem_write_enable_o     = {4{mem_req.write && !stall_i}};
    assign mem_address_o          = mem_req.address;
    assign mem_data_o             = mem_req.wdata;

endmodule

/* tb/rs5_lite_properties.sv */
// Port properties of the rs5_lite data memory interface
// Attached to every rs5_lite instance by bind

`include "rs5_lite_params.svh"

module rs5_lite_properties (
    input logic                 clk,
    input logic                 rst_n_i,
    input logic                 stall_i,
    input logic                 mem_enable_i,
    input logic [3:0]           mem_write_enable_i,
    input logic [`RS5_XLEN-1:0] mem_address_i,
    input logic [`RS5_XLEN-1:0] mem_data_i
);

    // Reset leaves the memory port idle
    reset_idle: assert property (@(posedge clk)
        !rst_n_i |=> !mem_enable_i)
        else $error("memory enable high after reset");

    // Load data cycle follows every read, no access in it
    read_then_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        (mem_enable_i && (mem_write_enable_i == 4'b0)) |=> !mem_enable_i)
        else $error("memory access in the load data cycle");

    // Stalled request waits unchanged for its retry
    request_held_in_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> ($stable(mem_address_i) && $stable(mem_data_i)))
        else $error("memory request changed during stall");

endmodule

bind rs5_lite rs5_lite_properties u_rs5_lite_properties (
    .clk                (clk),
    .rst_n_i            (rst_n_i),
    .stall_i            (stall_i),
    .mem_enable_i       (mem_operation_enable_o),
    .mem_write_enable_i (mem_write_enable_o),
    .mem_address_i      (mem_address_o),
    .mem_data_i         (mem_data_o)
);

/* tb/tb_rs5_lite.sv */
// rs5_lite testbench
// Instruction and data memory models, table of small programs,
// result checks against RV32I semantics and a closing report

`include "rs5_lite_params.svh"

module tb_rs5_lite;

    typedef enum int {K_ALU, K_IMM, K_CHAIN, K_BRANCH, K_LOAD, K_STALL} kind_e;

    typedef struct {
        kind_e                kind;
        rs5_lite_pkg::iop_e   op;
        logic [`RS5_XLEN-1:0] a;
        logic [`RS5_XLEN-1:0] b;
        logic [`RS5_XLEN-1:0] addr;
    } row_t;

    logic                 clk;
    logic                 rst_n_i;
    logic                 stall_i;
    logic [`RS5_XLEN-1:0] instruction_i;
    logic [`RS5_XLEN-1:0] mem_data_i;
    logic [`RS5_XLEN-1:0] instruction_address_o;
    logic                 mem_operation_enable_o;
    logic [3:0]           mem_write_enable_o;
    logic [`RS5_XLEN-1:0] mem_address_o;
    logic [`RS5_XLEN-1:0] mem_data_o;

    logic [`RS5_XLEN-1:0] imem [0:255];
    logic [`RS5_XLEN-1:0] dmem [0:255];
    int                   store_count [0:255];
    logic [7:0]           fetch_idx;
    logic                 rd_q, wr_q;
    logic [7:0]           data_idx;
    logic [`RS5_XLEN-1:0] wdata_q;
    logic                 stall_en;
    int                   seed;
    row_t                 table_q [$];
    int                   prog_len;
    int                   errors;

    rs5_lite u_rs5_lite (.*);

    always #50 clk = ~clk;

    ////////////////////////////////
    // Memory models
    ////////////////////////////////

    // Ports sampled mid-cycle where they have settled
    always @(negedge clk) begin
        fetch_idx = instruction_address_o[9:2];
        rd_q      = mem_operation_enable_o && (mem_write_enable_o == 4'b0);
        wr_q      = mem_operation_enable_o && (mem_write_enable_o != 4'b0);
        data_idx  = mem_address_o[9:2];
        wdata_q   = mem_data_o;
    end

    always @(posedge clk) begin
        if (wr_q) begin
            dmem[data_idx] = wdata_q;
            store_count[data_idx] = store_count[data_idx] + 1;
        end
        #10;
        instruction_i = imem[fetch_idx];
        if (rd_q) mem_data_i = dmem[data_idx];
        // Random stall only during the stall test
        stall_i = stall_en && (($random(seed) & 3) == 0);
    end

    ////////////////////////////////
    // Encoders and program builder
    ////////////////////////////////

    function automatic logic [31:0] enc_r(input [6:0] f7, input [2:0] f3,
                                          input [4:0] rd, input [4:0] rs1, input [4:0] rs2);
        enc_r = {f7, rs2, rs1, f3, rd, `RS5_OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input [6:0] opc, input [2:0] f3,
                                          input [4:0] rd, input [4:0] rs1, input [11:0] imm);
        enc_i = {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_sw(input [4:0] rs2, input [11:0] imm);
        enc_sw = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], `RS5_OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input [2:0] f3, input [4:0] rs1,
                                          input [4:0] rs2, input [12:0] imm);
        enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RS5_OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_jal(input [4:0] rd, input [20:0] imm);
        enc_jal = {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RS5_OPC_JAL};
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len = prog_len + 1;
    endtask

    // LUI plus ADDI with the upper part corrected for the sign of the low 12 bits
    task automatic load_const(input [4:0] rd, input logic [31:0] value);
        logic [11:0] lo;
        lo = value[11:0];
        emit({value[31:12] + {19'd0, value[11]}, rd, `RS5_OPC_LUI});
        emit(enc_i(`RS5_OPC_OP_IMM, 3'b000, rd, rd, lo));
    endtask

    function automatic logic [31:0] alu_ref(input rs5_lite_pkg::iop_e op,
                                            input logic [31:0] a, input logic [31:0] b);
        case (op)
            rs5_lite_pkg::OP_SUB: alu_ref = a - b;
            rs5_lite_pkg::OP_AND: alu_ref = a & b;
            rs5_lite_pkg::OP_OR:  alu_ref = a | b;
            rs5_lite_pkg::OP_XOR: alu_ref = a ^ b;
            rs5_lite_pkg::OP_SLT: alu_ref = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rs5_lite_pkg::OP_LUI: alu_ref = {b[31:12], 12'd0};
            default:              alu_ref = a + b;
        endcase
    endfunction

    function automatic logic [9:0] r_funct(input rs5_lite_pkg::iop_e op);
        case (op)
            rs5_lite_pkg::OP_SUB: r_funct = 10'b0100000_000;
            rs5_lite_pkg::OP_SLT: r_funct = 10'b0000000_010;
            rs5_lite_pkg::OP_XOR: r_funct = 10'b0000000_100;
            rs5_lite_pkg::OP_OR:  r_funct = 10'b0000000_110;
            rs5_lite_pkg::OP_AND: r_funct = 10'b0000000_111;
            default:              r_funct = 10'b0000000_000;
        endcase
    endfunction

    // Builds the program for one row and returns the expected stored word
    task automatic build(input row_t r, output logic [31:0] exp);
        logic [9:0]  fn;
        logic [11:0] sa;
        fn = r_funct(r.op);
        sa = r.addr[11:0];
        prog_len = 0;
        for (int i = 0; i < 256; i++) imem[i] = enc_i(`RS5_OPC_OP_IMM, 3'b000, 5'd0, 5'd0, 12'd0);
        load_const(5'd1, r.a);
        load_const(5'd2, r.b);
        case (r.kind)
            K_ALU: begin
                if (r.op == rs5_lite_pkg::OP_LUI) emit({r.b[31:12], 5'd3, `RS5_OPC_LUI});
                else emit(enc_r(fn[9:3], fn[2:0], 5'd3, 5'd1, 5'd2));
                exp = alu_ref(r.op, r.a, r.b);
            end
            K_IMM: begin
                emit(enc_i(`RS5_OPC_OP_IMM, 3'b000, 5'd3, 5'd1, r.b[11:0]));
                exp = r.a + {{20{r.b[11]}}, r.b[11:0]};
            end
            K_CHAIN, K_STALL: begin
                // Each ADD reads the rd of the one before
                emit(enc_r(7'd0, 3'b000, 5'd3, 5'd1, 5'd2));
                emit(enc_r(7'd0, 3'b000, 5'd4, 5'd3, 5'd1));
                emit(enc_r(7'd0, 3'b000, 5'd3, 5'd4, 5'd2));
                exp = (r.a + r.b) + r.a + r.b;
            end
            K_BRANCH: begin
                if (r.op == rs5_lite_pkg::OP_JAL) begin
                    exp = prog_len * 4 + 4;
                    emit(enc_jal(5'd3, 21'd8));
                    emit(enc_i(`RS5_OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 12'd222));
                end else begin
                    emit(enc_i(`RS5_OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 12'd111));
                    emit(enc_b(r.op == rs5_lite_pkg::OP_BEQ ? 3'b000 : 3'b001,
                               5'd1, 5'd2, 13'd8));
                    emit(enc_i(`RS5_OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 12'd222));
                    if ((r.op == rs5_lite_pkg::OP_BEQ) == (r.a == r.b)) exp = 32'd111;
                    else exp = 32'd222;
                end
            end
            default: begin
                // Store, load back into x3, and a write to x0 stored beside it
                emit(enc_sw(5'd1, sa + 12'h40));
                emit(enc_i(`RS5_OPC_LOAD, 3'b010, 5'd3, 5'd0, sa + 12'h40));
                emit(enc_i(`RS5_OPC_OP_IMM, 3'b000, 5'd0, 5'd1, 12'd5));
                emit(enc_sw(5'd0, sa + 12'h4));
                exp = r.a;
            end
        endcase
        emit(enc_sw(5'd3, sa));
    endtask

    task automatic add_row(input kind_e k, input rs5_lite_pkg::iop_e op,
                           input logic [31:0] a, input logic [31:0] b, input logic [31:0] addr);
        row_t r;
        r.kind = k;
        r.op   = op;
        r.a    = a;
        r.b    = b;
        r.addr = addr;
        table_q.push_back(r);
    endtask

    task automatic reset_dut();
        @(posedge clk);
        #10;
        rst_n_i = 1'b0;
        repeat (2) @(posedge clk);
        #10;
        rst_n_i = 1'b1;
    endtask

    ////////////////////////////////
    // Test sequence
    ////////////////////////////////

    initial begin
        logic [31:0] exp;
        logic [7:0]  idx;
        int          n;
        bit          ok;
        clk = 1'b0;
        rst_n_i = 1'b0;
        stall_i = 1'b0;
        instruction_i = '0;
        mem_data_i = '0;
        stall_en = 1'b0;
        seed = 32'h4a3ef04b;
        errors = 0;
        add_row(K_ALU, rs5_lite_pkg::OP_ADD, 32'd5, 32'd7, 32'h100);
        add_row(K_ALU, rs5_lite_pkg::OP_SUB, 32'd3, 32'd10, 32'h110);
        add_row(K_ALU, rs5_lite_pkg::OP_AND, 32'hf0f0_1234, 32'h0ff0_ff00, 32'h120);
        add_row(K_ALU, rs5_lite_pkg::OP_OR, 32'h1200_0081, 32'h0034_0f00, 32'h130);
        add_row(K_ALU, rs5_lite_pkg::OP_XOR, 32'hdead_beef, 32'h1234_5678, 32'h140);
        add_row(K_ALU, rs5_lite_pkg::OP_SLT, 32'hffff_fffb, 32'd3, 32'h150);
        add_row(K_ALU, rs5_lite_pkg::OP_SLT, 32'd7, 32'hffff_fffe, 32'h160);
        add_row(K_IMM, rs5_lite_pkg::OP_ADD, 32'h1234_5678, 32'h0000_0801, 32'h170);
        add_row(K_ALU, rs5_lite_pkg::OP_LUI, 32'd0, 32'habcd_e123, 32'h180);
        add_row(K_CHAIN, rs5_lite_pkg::OP_ADD, 32'd100, 32'd23, 32'h190);
        add_row(K_BRANCH, rs5_lite_pkg::OP_BEQ, 32'd9, 32'd9, 32'h1a0);
        add_row(K_BRANCH, rs5_lite_pkg::OP_BEQ, 32'd9, 32'd8, 32'h1b0);
        add_row(K_BRANCH, rs5_lite_pkg::OP_BNE, 32'd1, 32'd2, 32'h1c0);
        add_row(K_BRANCH, rs5_lite_pkg::OP_BNE, 32'd4, 32'd4, 32'h1d0);
        add_row(K_BRANCH, rs5_lite_pkg::OP_JAL, 32'd0, 32'd0, 32'h1e0);
        add_row(K_LOAD, rs5_lite_pkg::OP_LW, 32'h5a5a_1234, 32'd0, 32'h200);
        add_row(K_STALL, rs5_lite_pkg::OP_ADD, 32'h1111_0001, 32'h2222_0fff, 32'h240);
        foreach (table_q[t]) begin
            stall_en = (table_q[t].kind == K_STALL);
            build(table_q[t], exp);
            // Background pattern tied to the full word address
            for (int i = 0; i < 256; i++) begin
                dmem[i] = 32'hc0de_0000 ^ (i * 32'h0001_0101);
                store_count[i] = 0;
            end
            reset_dut();
            idx = table_q[t].addr[9:2];
            for (n = 0; n < 400 && store_count[idx] == 0; n++) @(negedge clk);
            // Extra cycles let a repeated store show up
            for (n = 0; n < 12; n++) @(negedge clk);
            stall_en = 1'b0;
            ok = 1'b1;
            if (store_count[idx] == 0) begin
                $display("test %0d: timed out, the result store never appeared", t);
                ok = 1'b0;
            end else begin
                assert (dmem[idx] == exp) else begin
                    $display("FAILED t=%0t test %0d: stored %h, expected %h",
                             $time, t, dmem[idx], exp);
                    ok = 1'b0;
                end
                assert (store_count[idx] == 1) else begin
                    $display("FAILED t=%0t test %0d: %0d stores to %h, expected 1",
                             $time, t, store_count[idx], table_q[t].addr);
                    ok = 1'b0;
                end
                if (table_q[t].kind == K_LOAD) begin
                    assert (dmem[idx + 8'd1] == 32'd0) else begin
                        $display("FAILED t=%0t test %0d: x0 stored as %h, expected 0",
                                 $time, t, dmem[idx + 8'd1]);
                        ok = 1'b0;
                    end
                end
            end
            if (!ok) errors = errors + 1;
            $display("test %0d op %s: %s", t, table_q[t].op.name(), ok ? "ok" : "wrong");
        end
        $display("tests run %0d, failed %0d", table_q.size(), errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* rs5_lite.f */
+incdir+hdl
hdl/rs5_lite_pkg.sv
hdl/pipe_ctrl.sv
hdl/pc_counter.sv
hdl/decode.sv
hdl/regbank.sv
hdl/execute.sv
hdl/rs5_lite.sv
tb/rs5_lite_properties.sv
tb/tb_rs5_lite.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the rs5_lite testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rs5_lite.f --top-module tb_rs5_lite \
    -o tb_rs5_lite_sim > build.log 2>&1 \
    && ./obj_dir/tb_rs5_lite_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "simulation did not run to completion"; exit 1; }

cat sim.log
grep -q "^TEST PASS$" sim.log && exit 0 || exit 1
